// ==== source/opl_pkg.sv ====
// Widths, register map, counter indices and the first-word header view
package opl_pkg;

	// ----------------------------------------------------------
	// Widths
	localparam int DATA_WIDTH     = 256;
	localparam int TUSER_WIDTH    = 128;
	localparam int MAC_WIDTH      = 48;
	localparam int REG_DATA_WIDTH = 32;
	localparam int REG_ADDR_WIDTH = 8;
	// Physical ports on even bits, CPU ports on odd bits
	localparam int NUM_PORTS      = 4;

	// Decoded Ethernet types
	localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
	localparam logic [15:0] ETHERTYPE_ARP  = 16'h0806;

	// ----------------------------------------------------------
	// Register word addresses
	localparam logic [REG_ADDR_WIDTH-1:0] REG_CLEAR       = 8'd0;
	// Odd addresses hold the low word, even ones the upper 16 bits
	localparam logic [REG_ADDR_WIDTH-1:0] REG_MAC0_LO     = 8'd1;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_MAC3_HI     = 8'd8;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_DEFAULT_OIF = 8'd9;
	localparam logic [REG_ADDR_WIDTH-1:0] REG_STATS_BASE  = 8'd16;

	// Counter slots
	localparam int STAT_ETH_BAD_DST = 0;
	localparam int STAT_NOT_IP4     = 1;
	localparam int STAT_ARP         = 2;
	localparam int STAT_TO_CPU      = 3;
	localparam int STAT_IP4_OPTIONS = 4;
	localparam int STAT_IP4_BAD_TTL = 5;
	localparam int STAT_IP4_FWD     = 6;
	localparam int NUM_STATS        = 7;

	// ----------------------------------------------------------
	// First beat of a packet, most significant byte on the wire first
	typedef struct packed {
		logic [MAC_WIDTH-1:0]   dst_mac;
		logic [MAC_WIDTH-1:0]   src_mac;
		logic [15:0]            eth_type;
		logic [3:0]             ip_version;
		logic [3:0]             ip_ihl;
		// TOS, total length, id, flags and fragment offset
		logic [55:0]            ip_skip;
		logic [7:0]             ip_ttl;
		// Protocol, checksum, addresses and the start of the payload
		logic [DATA_WIDTH-185:0] rest;
	} first_word_hdr_t;

	typedef union packed {
		logic [DATA_WIDTH-1:0] raw;
		first_word_hdr_t       hdr;
	} first_word_u;

endpackage

// ==== source/opl_cfg_if.sv ====
// Interface for router configuration from the register file to datapath and counters
`timescale 1ns/1ns

interface opl_cfg_if import opl_pkg::*; ();

	// Our own MAC addresses, one per physical port
	logic [NUM_PORTS-1:0][MAC_WIDTH-1:0] mac;
	// Stand-in for the forwarding table
	logic [7:0]                          default_oif;
	// Counters held at zero while high
	logic                                clear;

	// Register file owns everything
	modport reg_side (
		output mac,
		output default_oif,
		output clear
	);

	// Lookup datapath
	modport dp_side (
		input mac,
		input default_oif
	);

	// Statistics block
	modport stats_side (
		input clear
	);

endinterface

// ==== source/opl_reg_file.sv ====
// Register bus decode, configuration registers and counter readback
`timescale 1ns/1ns

module opl_reg_file import opl_pkg::*; (
	input  logic                                     AXI_ACLK,
	input  logic                                     i_rst_n,
	input  logic                                     i_reg_wr,
	input  logic                                     i_reg_rd,
	input  logic [REG_ADDR_WIDTH-1:0]                i_reg_addr,
	input  logic [REG_DATA_WIDTH-1:0]                i_reg_wdata,
	input  logic [NUM_STATS-1:0][REG_DATA_WIDTH-1:0] i_stats,
	output logic [REG_DATA_WIDTH-1:0]                o_reg_rdata,
	output logic                                     o_reg_ack,
	output logic                                     o_reg_err,
	opl_cfg_if.reg_side                              cfg
);

	localparam int MAC_HI_W   = MAC_WIDTH - REG_DATA_WIDTH;
	localparam int STAT_IDX_W = $clog2(NUM_STATS);

	// ----------------------------------------------------------
	// Storage
	logic                                     clear_r;
	logic [NUM_PORTS-1:0][REG_DATA_WIDTH-1:0] mac_lo;
	logic [NUM_PORTS-1:0][MAC_HI_W-1:0]       mac_hi;
	logic [7:0]                               oif_r;

	// Decode
	logic                      is_clear;
	logic                      is_mac;
	logic                      is_oif;
	logic                      is_stat;
	logic                      req_err;
	logic [REG_ADDR_WIDTH-1:0] mac_off;
	logic [REG_ADDR_WIDTH-1:0] stat_off;
	logic [1:0]                mac_idx;
	logic                      mac_hi_sel;
	logic [REG_DATA_WIDTH-1:0] rd_word;

	assign is_clear   = (i_reg_addr == REG_CLEAR);
	assign is_mac     = (i_reg_addr >= REG_MAC0_LO) && (i_reg_addr <= REG_MAC3_HI);
	assign is_oif     = (i_reg_addr == REG_DEFAULT_OIF);
	assign stat_off   = i_reg_addr - REG_STATS_BASE;
	assign is_stat    = (i_reg_addr >= REG_STATS_BASE) && (stat_off < NUM_STATS);
	// LO and HI words alternate from MAC0
	assign mac_off    = i_reg_addr - REG_MAC0_LO;
	assign mac_idx    = mac_off[2:1];
	assign mac_hi_sel = mac_off[0];

	// Unmapped address, or a write into the read-only counter window
	assign req_err = !(is_clear || is_mac || is_oif || is_stat) || (i_reg_wr && is_stat);

	// Read mux, unmapped reads give zero
	always_comb begin
		rd_word = '0;
		if (is_clear)
			rd_word = {{(REG_DATA_WIDTH-1){1'b0}}, clear_r};
		else if (is_mac && mac_hi_sel)
			rd_word = {{(REG_DATA_WIDTH-MAC_HI_W){1'b0}}, mac_hi[mac_idx]};
		else if (is_mac)
			rd_word = mac_lo[mac_idx];
		else if (is_oif)
			rd_word = {{(REG_DATA_WIDTH-8){1'b0}}, oif_r};
		else if (is_stat)
			rd_word = i_stats[stat_off[STAT_IDX_W-1:0]];
	end

	// ----------------------------------------------------------
	// Writes and the one-cycle acknowledge
	always_ff @(posedge AXI_ACLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_reg_ack   <= 1'b0;
			o_reg_err   <= 1'b0;
			o_reg_rdata <= '0;
			clear_r     <= 1'b0;
			mac_lo      <= '0;
			mac_hi      <= '0;
			oif_r       <= '0;
		end else begin
			o_reg_ack   <= i_reg_wr | i_reg_rd;
			o_reg_err   <= (i_reg_wr | i_reg_rd) & req_err;
			o_reg_rdata <= i_reg_rd ? rd_word : '0;
			if (i_reg_wr && is_clear)
				clear_r <= i_reg_wdata[0];
			if (i_reg_wr && is_mac && mac_hi_sel)
				mac_hi[mac_idx] <= i_reg_wdata[MAC_HI_W-1:0];
			if (i_reg_wr && is_mac && !mac_hi_sel)
				mac_lo[mac_idx] <= i_reg_wdata;
			if (i_reg_wr && is_oif)
				oif_r <= i_reg_wdata[7:0];
		end
	end

	// Full MACs out to the datapath
	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++)
			cfg.mac[i] = {mac_hi[i], mac_lo[i]};
	end
	assign cfg.default_oif = oif_r;
	assign cfg.clear       = clear_r;

	// Host issues one request at a time
	a_one_request: assert property (@(posedge AXI_ACLK) disable iff (!i_rst_n)
		!(i_reg_wr && i_reg_rd));

endmodule

// ==== source/opl_stats.sv ====
// Statistics counters with a level clear
`timescale 1ns/1ns

module opl_stats import opl_pkg::*; (
	input  logic                                     AXI_ACLK,
	input  logic                                     i_rst_n,
	// One pulse per packet from the output stage
	input  logic [NUM_STATS-1:0]                     i_event,
	opl_cfg_if.stats_side                            cfg,
	output logic [NUM_STATS-1:0][REG_DATA_WIDTH-1:0] o_stats
);

	// ----------------------------------------------------------
	// Counters
	// Clear wins over a same-cycle event
	// Wrap at 2^32 with no saturation
	always_ff @(posedge AXI_ACLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_stats <= '0;
		end else begin
			for (int i = 0; i < NUM_STATS; i++) begin
				if (cfg.clear)
					o_stats[i] <= '0;
				else if (i_event[i])
					o_stats[i] <= o_stats[i] + 1'b1;
			end
		end
	end

	// At most one verdict counter per packet
	a_one_verdict: assert property (@(posedge AXI_ACLK) disable iff (!i_rst_n)
		$onehot0({i_event[STAT_ETH_BAD_DST], i_event[STAT_TO_CPU], i_event[STAT_IP4_FWD]}));

endmodule

// ==== source/opl_classify.sv ====
// Forwarding verdict and statistics events from the first word of a packet
`timescale 1ns/1ns

module opl_classify import opl_pkg::*; #(
	parameter int SRC_PORT_POS = 16
) (
	input  first_word_u             i_word,
	input  logic [TUSER_WIDTH-1:0]  i_tuser,
	opl_cfg_if.dp_side              cfg,
	output logic                    o_drop,
	output logic [7:0]              o_dst_port,
	output logic [NUM_STATS-1:0]    o_event
);

	logic [7:0]           src_port;
	logic [7:0]           cpu_mask;
	logic                 from_cpu;
	logic                 for_us;
	logic                 bcast;
	logic                 is_ipv4;
	logic                 is_arp;
	logic                 ip_opts;
	logic                 ttl_low;

	// ----------------------------------------------------------
	// Field checks
	assign src_port = i_tuser[SRC_PORT_POS +: 8];

	// Odd bits of the port byte are CPU queues
	always_comb begin
		cpu_mask = '0;
		for (int i = 0; i < NUM_PORTS; i++)
			cpu_mask[2*i+1] = 1'b1;
	end
	assign from_cpu = |(src_port & cpu_mask);

	// Destination MAC against the four port addresses
	always_comb begin
		for_us = 1'b0;
		for (int i = 0; i < NUM_PORTS; i++)
			if (cfg.mac[i] == i_word.hdr.dst_mac)
				for_us = 1'b1;
	end
	assign bcast   = &i_word.hdr.dst_mac;
	assign is_ipv4 = (i_word.hdr.eth_type == ETHERTYPE_IPV4);
	assign is_arp  = (i_word.hdr.eth_type == ETHERTYPE_ARP);
	// Version other than 4 is lumped in with options
	assign ip_opts = (i_word.hdr.ip_version != 4'd4) || (i_word.hdr.ip_ihl != 4'd5);
	assign ttl_low = (i_word.hdr.ip_ttl <= 8'd1);

	// ----------------------------------------------------------
	// Verdict, first matching rule wins
	always_comb begin
		o_drop     = 1'b0;
		o_dst_port = '0;
		o_event    = '0;
		if (from_cpu) begin
			// CPU queue to its physical port, not counted
			o_dst_port = src_port >> 1;
		end else if (!(for_us || bcast)) begin
			o_drop                    = 1'b1;
			o_event[STAT_ETH_BAD_DST] = 1'b1;
		end else if (bcast || !is_ipv4) begin
			o_dst_port            = src_port << 1;
			o_event[STAT_TO_CPU]  = 1'b1;
			o_event[STAT_NOT_IP4] = !is_ipv4;
			o_event[STAT_ARP]     = is_arp;
		end else if (ip_opts) begin
			o_dst_port                = src_port << 1;
			o_event[STAT_TO_CPU]      = 1'b1;
			o_event[STAT_IP4_OPTIONS] = 1'b1;
		end else if (ttl_low) begin
			o_dst_port                = src_port << 1;
			o_event[STAT_TO_CPU]      = 1'b1;
			o_event[STAT_IP4_BAD_TTL] = 1'b1;
		end else begin
			o_dst_port            = cfg.default_oif;
			o_event[STAT_IP4_FWD] = 1'b1;
		end
	end

endmodule

// ==== source/opl_forward.sv ====
// Stream output register applying the packet verdict and gating counter events
`timescale 1ns/1ns

module opl_forward import opl_pkg::*; #(
	parameter int DST_PORT_POS = 24
) (
	input  logic                    AXI_ACLK,
	input  logic                    i_rst_n,
	// Slave stream
	input  logic [DATA_WIDTH-1:0]   i_s_tdata,
	input  logic [TUSER_WIDTH-1:0]  i_s_tuser,
	input  logic                    i_s_tvalid,
	input  logic                    i_s_tlast,
	output logic                    o_s_tready,
	// Master stream
	input  logic                    i_m_tready,
	output logic [DATA_WIDTH-1:0]   o_m_tdata,
	output logic [TUSER_WIDTH-1:0]  o_m_tuser,
	output logic                    o_m_tvalid,
	output logic                    o_m_tlast,
	// Verdict from the classifier
	output first_word_u             o_word,
	input  logic                    i_drop,
	input  logic [7:0]              i_dst_port,
	input  logic [NUM_STATS-1:0]    i_event,
	output logic [NUM_STATS-1:0]    o_event
);

	logic                   accept;
	logic                   first_beat;
	logic                   drop_r;
	logic [7:0]             dst_r;
	logic                   cur_drop;
	logic [7:0]             cur_dst;
	logic                   keep;
	logic [TUSER_WIDTH-1:0] tuser_out;

	// Header view of the incoming beat for the classifier
	assign o_word.raw = i_s_tdata;

	// Empty slot or the slot drains this cycle
	assign o_s_tready = !o_m_tvalid || i_m_tready;
	assign accept     = i_s_tvalid && o_s_tready;

	// ----------------------------------------------------------
	// Verdict tracking
	// Live verdict on the first beat, latched copy after it
	assign cur_drop = first_beat ? i_drop : drop_r;
	assign cur_dst  = first_beat ? i_dst_port : dst_r;
	assign keep     = accept && !cur_drop;

	always_ff @(posedge AXI_ACLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			first_beat <= 1'b1;
			drop_r     <= 1'b0;
			dst_r      <= '0;
		end else if (accept) begin
			// Next beat starts a packet after TLAST
			first_beat <= i_s_tlast;
			if (first_beat) begin
				drop_r <= i_drop;
				dst_r  <= i_dst_port;
			end
		end
	end

	// Destination byte rewritten, other TUSER bits untouched
	always_comb begin
		tuser_out                      = i_s_tuser;
		tuser_out[DST_PORT_POS +: 8]   = cur_dst;
	end

	// ----------------------------------------------------------
	// Output register
	always_ff @(posedge AXI_ACLK or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_m_tvalid <= 1'b0;
			o_m_tdata  <= '0;
			o_m_tuser  <= '0;
			o_m_tlast  <= 1'b0;
		end else if (o_s_tready) begin
			o_m_tvalid <= keep;
			if (keep) begin
				o_m_tdata <= i_s_tdata;
				o_m_tuser <= tuser_out;
				o_m_tlast <= i_s_tlast;
			end
		end
	end

	// One event pulse per packet
	assign o_event = (accept && first_beat) ? i_event : '0;

	// Held beat does not move under back-pressure
	a_stall_stable: assert property (@(posedge AXI_ACLK) disable iff (!i_rst_n)
		(o_m_tvalid && !i_m_tready) |=>
		(o_m_tvalid && $stable(o_m_tdata) && $stable(o_m_tuser) && $stable(o_m_tlast)));

	// A packet counted as a bad destination leaves no beat
	a_drop_counted: assert property (@(posedge AXI_ACLK) disable iff (!i_rst_n)
		o_event[STAT_ETH_BAD_DST] |-> !keep);

endmodule

// ==== source/router_opl_top.sv ====
// Output port lookup top level wiring registers, counters, classifier and output stage
`timescale 1ns/1ns

module router_opl_top import opl_pkg::*; #(
	parameter int SRC_PORT_POS = 16,
	parameter int DST_PORT_POS = 24
) (
	input  logic                       AXI_ACLK,
	input  logic                       i_rst_n,
	// Slave stream from the RX queues
	input  logic [DATA_WIDTH-1:0]      i_s_tdata,
	input  logic [TUSER_WIDTH-1:0]     i_s_tuser,
	input  logic                       i_s_tvalid,
	input  logic                       i_s_tlast,
	output logic                       o_s_tready,
	// Master stream to the TX path
	input  logic                       i_m_tready,
	output logic [DATA_WIDTH-1:0]      o_m_tdata,
	output logic [TUSER_WIDTH-1:0]     o_m_tuser,
	output logic                       o_m_tvalid,
	output logic                       o_m_tlast,
	// Register strobe bus
	input  logic                       i_reg_wr,
	input  logic                       i_reg_rd,
	input  logic [REG_ADDR_WIDTH-1:0]  i_reg_addr,
	input  logic [REG_DATA_WIDTH-1:0]  i_reg_wdata,
	output logic [REG_DATA_WIDTH-1:0]  o_reg_rdata,
	output logic                       o_reg_ack,
	output logic                       o_reg_err
);

	// ----------------------------------------------------------
	// Internal wiring
	first_word_u                              w_word;
	logic                                     w_drop;
	logic [7:0]                               w_dst_port;
	logic [NUM_STATS-1:0]                     w_cls_event;
	logic [NUM_STATS-1:0]                     w_fwd_event;
	logic [NUM_STATS-1:0][REG_DATA_WIDTH-1:0] w_stats;

	// Configuration bundle
	opl_cfg_if u_cfg ();

	// Software registers and counter readback
	opl_reg_file u_reg_file (
		.AXI_ACLK    (AXI_ACLK),
		.i_rst_n     (i_rst_n),
		.i_reg_wr    (i_reg_wr),
		.i_reg_rd    (i_reg_rd),
		.i_reg_addr  (i_reg_addr),
		.i_reg_wdata (i_reg_wdata),
		.i_stats     (w_stats),
		.o_reg_rdata (o_reg_rdata),
		.o_reg_ack   (o_reg_ack),
		.o_reg_err   (o_reg_err),
		.cfg         (u_cfg.reg_side)
	);

	opl_stats u_stats (
		.AXI_ACLK (AXI_ACLK),
		.i_rst_n  (i_rst_n),
		.i_event  (w_fwd_event),
		.cfg      (u_cfg.stats_side),
		.o_stats  (w_stats)
	);

	// Combinational decision on the current beat
	opl_classify #(
		.SRC_PORT_POS (SRC_PORT_POS)
	) u_classify (
		.i_word     (w_word),
		.i_tuser    (i_s_tuser),
		.cfg        (u_cfg.dp_side),
		.o_drop     (w_drop),
		.o_dst_port (w_dst_port),
		.o_event    (w_cls_event)
	);

	opl_forward #(
		.DST_PORT_POS (DST_PORT_POS)
	) u_forward (
		.AXI_ACLK   (AXI_ACLK),
		.i_rst_n    (i_rst_n),
		.i_s_tdata  (i_s_tdata),
		.i_s_tuser  (i_s_tuser),
		.i_s_tvalid (i_s_tvalid),
		.i_s_tlast  (i_s_tlast),
		.o_s_tready (o_s_tready),
		.i_m_tready (i_m_tready),
		.o_m_tdata  (o_m_tdata),
		.o_m_tuser  (o_m_tuser),
		.o_m_tvalid (o_m_tvalid),
		.o_m_tlast  (o_m_tlast),
		.o_word     (w_word),
		.i_drop     (w_drop),
		.i_dst_port (w_dst_port),
		.i_event    (w_cls_event),
		.o_event    (w_fwd_event)
	);

endmodule

// ==== tests/tb_opl_model.svh ====
// Reference model of the lookup rules, packet builder, expected-output queue and compare tasks
`ifndef TB_OPL_MODEL_SVH
`define TB_OPL_MODEL_SVH

// ------------------------------------------------------------
// Model state
// Kept beats in the order they must leave
logic [DATA_WIDTH-1:0]     exp_data[$];
logic [TUSER_WIDTH-1:0]    exp_user[$];
logic                      exp_last[$];
// Counter tally since the last clear
logic [REG_DATA_WIDTH-1:0] exp_cnt[NUM_STATS];
// Configuration as written over the register bus
logic [MAC_WIDTH-1:0]      our_mac[NUM_PORTS];
logic [7:0]                oif;
// Low while the counters are held in clear
bit                        counting;

function automatic bit mac_is_ours(input logic [MAC_WIDTH-1:0] m);
	for (int i = 0; i < NUM_PORTS; i++) begin
		if (our_mac[i] == m)
			return 1'b1;
	end
	return 1'b0;
endfunction

// First word, header fields most significant byte first
// Source MAC, skipped IPv4 bytes and tail come from the fill word
function automatic logic [DATA_WIDTH-1:0] build_first(
	input logic [MAC_WIDTH-1:0]  dmac,
	input logic [15:0]           etype,
	input logic [3:0]            ver,
	input logic [3:0]            ihl,
	input logic [7:0]            ttl,
	input logic [DATA_WIDTH-1:0] fill
);
	return {dmac, fill[207:160], etype, ver, ihl, fill[135:80], ttl, fill[71:0]};
endfunction

// ------------------------------------------------------------
// Lookup rules, first match wins
task automatic predict(
	input  logic [MAC_WIDTH-1:0] dmac,
	input  logic [15:0]          etype,
	input  logic [3:0]           ver,
	input  logic [3:0]           ihl,
	input  logic [7:0]           ttl,
	input  logic [7:0]           src,
	output logic                 drop,
	output logic [7:0]           dst,
	output logic [NUM_STATS-1:0] ev
);
	logic bcast;
	bcast = (dmac == {MAC_WIDTH{1'b1}});
	drop  = 1'b0;
	dst   = src << 1;
	ev    = '0;
	if (src[1] | src[3] | src[5] | src[7]) begin
		// From a CPU queue, out its own physical port
		dst = src >> 1;
	end else if (!bcast && !mac_is_ours(dmac)) begin
		drop                 = 1'b1;
		ev[STAT_ETH_BAD_DST] = 1'b1;
	end else if (bcast || etype != ETHERTYPE_IPV4) begin
		ev[STAT_TO_CPU]  = 1'b1;
		ev[STAT_NOT_IP4] = (etype != ETHERTYPE_IPV4);
		ev[STAT_ARP]     = (etype == ETHERTYPE_ARP);
	end else if (ver != 4'd4 || ihl != 4'd5) begin
		ev[STAT_TO_CPU]      = 1'b1;
		ev[STAT_IP4_OPTIONS] = 1'b1;
	end else if (ttl < 8'd2) begin
		ev[STAT_TO_CPU]      = 1'b1;
		ev[STAT_IP4_BAD_TTL] = 1'b1;
	end else begin
		dst               = oif;
		ev[STAT_IP4_FWD]  = 1'b1;
	end
	if (counting) begin
		for (int i = 0; i < NUM_STATS; i++)
			exp_cnt[i] = exp_cnt[i] + ev[i];
	end
endtask

// Kept beat with the destination byte replaced
task automatic queue_beat(
	input logic [DATA_WIDTH-1:0]  d,
	input logic [TUSER_WIDTH-1:0] u,
	input logic                   last,
	input logic [7:0]             dst
);
	logic [TUSER_WIDTH-1:0] eu;
	eu              = u;
	eu[DST_POS +: 8] = dst;
	exp_data.push_back(d);
	exp_user.push_back(eu);
	exp_last.push_back(last);
endtask

// ------------------------------------------------------------
// Compare tasks
task automatic check_beat(
	input logic [DATA_WIDTH-1:0]  got_d,
	input logic [DATA_WIDTH-1:0]  exp_d,
	input logic [TUSER_WIDTH-1:0] got_u,
	input logic [TUSER_WIDTH-1:0] exp_u,
	input logic                   got_l,
	input logic                   exp_l
);
	if (got_d !== exp_d) begin
		value_errors++;
		$display("FAILED o_m_tdata got %h expected %h", got_d, exp_d);
	end
	if (got_u !== exp_u) begin
		value_errors++;
		$display("FAILED o_m_tuser got %h expected %h", got_u, exp_u);
	end
	if (got_l !== exp_l) begin
		value_errors++;
		$display("FAILED o_m_tlast got %h expected %h", got_l, exp_l);
	end
endtask

task automatic check_reg(
	input string                     name,
	input logic [REG_DATA_WIDTH-1:0] got,
	input logic [REG_DATA_WIDTH-1:0] exp
);
	if (got !== exp) begin
		value_errors++;
		$display("FAILED %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		value_errors++;
		$display("FAILED %s got %h expected %h", name, got, exp);
	end
endtask

`endif

// ==== tests/tb_router_opl.sv ====
// Testbench top with clock, reset, LFSR, register bus tasks, stream stimulus and final report
`timescale 1ns/1ns

module tb_router_opl import opl_pkg::*; ();

	localparam int SRC_POS     = 16;
	localparam int DST_POS     = 24;
	localparam int TIMEOUT     = 200;
	localparam int REG_TIMEOUT = 20;

	logic                      AXI_ACLK;
	logic                      i_rst_n;
	logic [DATA_WIDTH-1:0]     i_s_tdata;
	logic [TUSER_WIDTH-1:0]    i_s_tuser;
	logic                      i_s_tvalid;
	logic                      i_s_tlast;
	logic                      o_s_tready;
	logic                      i_m_tready;
	logic [DATA_WIDTH-1:0]     o_m_tdata;
	logic [TUSER_WIDTH-1:0]    o_m_tuser;
	logic                      o_m_tvalid;
	logic                      o_m_tlast;
	logic                      i_reg_wr;
	logic                      i_reg_rd;
	logic [REG_ADDR_WIDTH-1:0] i_reg_addr;
	logic [REG_DATA_WIDTH-1:0] i_reg_wdata;
	logic [REG_DATA_WIDTH-1:0] o_reg_rdata;
	logic                      o_reg_ack;
	logic                      o_reg_err;

	int          value_errors;
	int          proto_errors;
	int          timeouts;
	logic [31:0] lfsr;
	// Random output stall when set
	bit          bp_on;

	`include "tb_opl_model.svh"

	router_opl_top #(
		.SRC_PORT_POS (SRC_POS),
		.DST_PORT_POS (DST_POS)
	) u_dut (
		.AXI_ACLK    (AXI_ACLK),
		.i_rst_n     (i_rst_n),
		.i_s_tdata   (i_s_tdata),
		.i_s_tuser   (i_s_tuser),
		.i_s_tvalid  (i_s_tvalid),
		.i_s_tlast   (i_s_tlast),
		.o_s_tready  (o_s_tready),
		.i_m_tready  (i_m_tready),
		.o_m_tdata   (o_m_tdata),
		.o_m_tuser   (o_m_tuser),
		.o_m_tvalid  (o_m_tvalid),
		.o_m_tlast   (o_m_tlast),
		.i_reg_wr    (i_reg_wr),
		.i_reg_rd    (i_reg_rd),
		.i_reg_addr  (i_reg_addr),
		.i_reg_wdata (i_reg_wdata),
		.o_reg_rdata (o_reg_rdata),
		.o_reg_ack   (o_reg_ack),
		.o_reg_err   (o_reg_err)
	);

	initial begin
		AXI_ACLK = 1'b0;
		forever #5 AXI_ACLK = ~AXI_ACLK;
	end

	// ------------------------------------------------------------
	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic lfsr_step();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], lfsr_step()};
		return r;
	endfunction

	function automatic logic [DATA_WIDTH-1:0] rand_wide(input int n);
		logic [DATA_WIDTH-1:0] r;
		r = '0;
		for (int i = 0; i < n / 32; i++)
			r = {r[DATA_WIDTH-33:0], rand_bits(32)};
		return r;
	endfunction

	// ------------------------------------------------------------
	// Register bus, request pulse then wait for the acknowledge
	task automatic reg_access(
		input  logic                      wr,
		input  logic [REG_ADDR_WIDTH-1:0] addr,
		input  logic [REG_DATA_WIDTH-1:0] wdata,
		output logic [REG_DATA_WIDTH-1:0] rdata,
		output logic                      err
	);
		int n;
		@(negedge AXI_ACLK);
		i_reg_wr    = wr;
		i_reg_rd    = !wr;
		i_reg_addr  = addr;
		i_reg_wdata = wdata;
		@(negedge AXI_ACLK);
		i_reg_wr = 1'b0;
		i_reg_rd = 1'b0;
		n = 0;
		while (!o_reg_ack && n < REG_TIMEOUT) begin
			@(negedge AXI_ACLK);
			n++;
		end
		if (!o_reg_ack) begin
			timeouts++;
			$display("Register access to address %h was never acknowledged", addr);
		end
		rdata = o_reg_rdata;
		err   = o_reg_err;
		// Acknowledge lasts one cycle only
		@(negedge AXI_ACLK);
		check_flag("o_reg_ack", o_reg_ack, 1'b0);
	endtask

	task automatic reg_write(input logic [REG_ADDR_WIDTH-1:0] addr,
		input logic [REG_DATA_WIDTH-1:0] data, input logic exp_err);
		logic [REG_DATA_WIDTH-1:0] rd;
		logic                      err;
		reg_access(1'b1, addr, data, rd, err);
		check_flag($sformatf("o_reg_err @%0d", addr), err, exp_err);
	endtask

	task automatic reg_read(input logic [REG_ADDR_WIDTH-1:0] addr,
		input logic [REG_DATA_WIDTH-1:0] exp, input logic exp_err);
		logic [REG_DATA_WIDTH-1:0] rd;
		logic                      err;
		reg_access(1'b0, addr, '0, rd, err);
		check_reg($sformatf("o_reg_rdata @%0d", addr), rd, exp);
		check_flag($sformatf("o_reg_err @%0d", addr), err, exp_err);
	endtask

	task automatic check_counters();
		for (int i = 0; i < NUM_STATS; i++)
			reg_read(REG_STATS_BASE + 8'(i), exp_cnt[i], 1'b0);
	endtask

	// ------------------------------------------------------------
	// Stream, drive on the falling edge and look 1 ns later
	task automatic watch_output();
		logic [DATA_WIDTH-1:0]  d;
		logic [TUSER_WIDTH-1:0] u;
		logic                   l;
		if (o_m_tvalid && i_m_tready) begin
			if (exp_data.size() == 0) begin
				proto_errors++;
				$display("Output beat appeared while no beat was expected");
			end else begin
				d = exp_data.pop_front();
				u = exp_user.pop_front();
				l = exp_last.pop_front();
				check_beat(o_m_tdata, d, o_m_tuser, u, o_m_tlast, l);
			end
		end
	endtask

	task automatic stream_cycle(input logic valid, input logic [DATA_WIDTH-1:0] d,
		input logic [TUSER_WIDTH-1:0] u, input logic last, output logic acc);
		@(negedge AXI_ACLK);
		i_m_tready = bp_on ? (rand_bits(2) != 0) : 1'b1;
		i_s_tvalid = valid;
		i_s_tdata  = d;
		i_s_tuser  = u;
		i_s_tlast  = last;
		#1;
		watch_output();
		acc = valid && o_s_tready;
	endtask

	task automatic send_beat(input logic [DATA_WIDTH-1:0] d,
		input logic [TUSER_WIDTH-1:0] u, input logic last);
		logic acc;
		int   n;
		acc = 1'b0;
		n   = 0;
		while (!acc && n < TIMEOUT) begin
			stream_cycle(1'b1, d, u, last, acc);
			n++;
		end
		if (!acc) begin
			timeouts++;
			$display("Input beat was not accepted within %0d cycles", TIMEOUT);
		end
	endtask

	// Random header, source port and length, then model and send
	task automatic send_packet();
		logic [2:0]             sel;
		logic [1:0]             tsel;
		logic [MAC_WIDTH-1:0]   dmac;
		logic [15:0]            etype;
		logic [3:0]             ver;
		logic [3:0]             ihl;
		logic [7:0]             ttl;
		logic [7:0]             src;
		logic [7:0]             dst;
		logic                   drop;
		logic                   acc;
		logic [NUM_STATS-1:0]   ev;
		logic [DATA_WIDTH-1:0]  d;
		logic [TUSER_WIDTH-1:0] u;
		int                     port;
		int                     nbeats;
		sel = 3'(rand_bits(3));
		if (sel < 4)
			dmac = our_mac[sel];
		else if (sel == 4)
			dmac = '1;
		else
			dmac = {8'h04, rand_bits(32), 8'(rand_bits(8))};
		tsel  = 2'(rand_bits(2));
		etype = (tsel < 2) ? ETHERTYPE_IPV4 : (tsel == 2) ? ETHERTYPE_ARP : 16'h86dd;
		ver   = (rand_bits(3) == 0) ? 4'd6 : 4'd4;
		ihl   = (rand_bits(3) == 0) ? 4'd6 : 4'd5;
		if (rand_bits(2) == 0)
			ttl = 8'(rand_bits(1));
		else
			ttl = 8'd2 + 8'(rand_bits(7));
		port = 2 * int'(rand_bits(2));
		if (rand_bits(2) == 0)
			port = port + 1;
		src    = 8'h01 << port;
		nbeats = 1 + int'(rand_bits(2));
		predict(dmac, etype, ver, ihl, ttl, src, drop, dst, ev);
		for (int b = 0; b < nbeats; b++) begin
			d = rand_wide(DATA_WIDTH);
			if (b == 0)
				d = build_first(dmac, etype, ver, ihl, ttl, d);
			u = TUSER_WIDTH'(rand_wide(TUSER_WIDTH));
			u[SRC_POS +: 8] = src;
			if (!drop)
				queue_beat(d, u, b == nbeats - 1, dst);
			send_beat(d, u, b == nbeats - 1);
		end
		// Occasional gap between packets
		if (rand_bits(2) == 0)
			stream_cycle(1'b0, '0, '0, 1'b0, acc);
	endtask

	task automatic drain();
		logic acc;
		int   n;
		n = 0;
		while (exp_data.size() > 0 && n < TIMEOUT) begin
			stream_cycle(1'b0, '0, '0, 1'b0, acc);
			n++;
		end
		if (exp_data.size() > 0) begin
			timeouts++;
			$display("Output stalled with %0d beats still expected", exp_data.size());
		end
		// Catch any beat that should not be there
		repeat (3) stream_cycle(1'b0, '0, '0, 1'b0, acc);
	endtask

	// ------------------------------------------------------------
	// Main sequence
	initial begin
		logic [REG_DATA_WIDTH-1:0] lo;
		lfsr         = 32'h637e;
		value_errors = 0;
		proto_errors = 0;
		timeouts     = 0;
		counting     = 1'b1;
		bp_on        = 1'b0;
		for (int i = 0; i < NUM_STATS; i++)
			exp_cnt[i] = '0;
		i_rst_n     = 1'b0;
		i_s_tdata   = '0;
		i_s_tuser   = '0;
		i_s_tvalid  = 1'b0;
		i_s_tlast   = 1'b0;
		i_m_tready  = 1'b1;
		i_reg_wr    = 1'b0;
		i_reg_rd    = 1'b0;
		i_reg_addr  = '0;
		i_reg_wdata = '0;
		repeat (3) @(posedge AXI_ACLK);
		@(negedge AXI_ACLK);
		i_rst_n = 1'b1;
		check_flag("o_m_tvalid", o_m_tvalid, 1'b0);
		check_flag("o_reg_ack", o_reg_ack, 1'b0);
		check_flag("o_reg_err", o_reg_err, 1'b0);

		// MACs share a prefix, index in the second byte
		for (int i = 0; i < NUM_PORTS; i++) begin
			lo         = rand_bits(32);
			our_mac[i] = {8'h02, 8'(i), lo};
			reg_write(REG_MAC0_LO + 8'(2 * i), lo, 1'b0);
			reg_write(REG_MAC0_LO + 8'(2 * i + 1), {16'h0, 8'h02, 8'(i)}, 1'b0);
		end
		oif = 8'h01 << (2 * int'(rand_bits(2)));
		reg_write(REG_DEFAULT_OIF, {24'h0, oif}, 1'b0);
		for (int i = 0; i < NUM_PORTS; i++) begin
			reg_read(REG_MAC0_LO + 8'(2 * i), our_mac[i][31:0], 1'b0);
			reg_read(REG_MAC0_LO + 8'(2 * i + 1), {16'h0, our_mac[i][47:32]}, 1'b0);
		end
		reg_read(REG_DEFAULT_OIF, {24'h0, oif}, 1'b0);
		reg_read(REG_CLEAR, '0, 1'b0);
		// Counter window is read only, holes read zero
		reg_write(REG_STATS_BASE, 32'h5, 1'b1);
		reg_write(8'd12, 32'h1, 1'b1);
		reg_read(8'd12, '0, 1'b1);
		reg_read(REG_STATS_BASE + 8'(NUM_STATS), '0, 1'b1);
		check_counters();

		// Free-running output, then random stalls
		repeat (40) send_packet();
		drain();
		check_counters();
		bp_on = 1'b1;
		repeat (80) send_packet();
		drain();
		check_counters();

		// Counters held at zero under clear
		reg_write(REG_CLEAR, 32'h1, 1'b0);
		counting = 1'b0;
		for (int i = 0; i < NUM_STATS; i++)
			exp_cnt[i] = '0;
		repeat (10) send_packet();
		drain();
		check_counters();
		reg_read(REG_CLEAR, 32'h1, 1'b0);
		reg_write(REG_CLEAR, 32'h0, 1'b0);
		counting = 1'b1;
		repeat (30) send_packet();
		drain();
		check_counters();

		$display("Errors: %0d value, %0d protocol, %0d timeout",
			value_errors, proto_errors, timeouts);
		if (value_errors == 0 && proto_errors == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+tests
source/opl_pkg.sv
source/opl_cfg_if.sv
source/opl_reg_file.sv
source/opl_stats.sv
source/opl_classify.sv
source/opl_forward.sv
source/router_opl_top.sv
tests/tb_router_opl.sv
